//--- gatedDomain.sv
/*
  Behavioural model of the switchable domain.
  Clock gating is an enable on the flops, not a real gated clock.
  Powered-off flops read back as lostData until restored or reset.
  dataOut is clamped to 0 while isolate is high.
*/
`timescale 1ns/1ps
`default_nettype none

module gatedDomain
  import pwrCtrlPkg::*;
(
  input  logic        pclk12,
  input  logic        nprst12,
  // Work pulse, counted and used to capture dataIn
  input  logic        work,
  input  domainData_t dataIn,
  input  domainCtrl_t domainCtrl,
  // Shadow value from the retention store
  input  domainData_t savedCount,
  output domainData_t liveCount,
  output domainData_t dataOut
);

  domainData_t retCount;
  domainData_t plainReg;
  logic        clkEn;
  logic        railsUp;

  // Gated clock seen as an enable
  assign clkEn   = !domainCtrl.gateClk;
  // Both switches closed
  assign railsUp = domainCtrl.pwr1On & domainCtrl.pwr2On;

  // ------------------------------
  // Retained counter
  // ------------------------------
  always_ff @(posedge pclk12 or negedge nprst12)
  begin
    if (!nprst12)
    begin
      retCount <= '0;
    end
    else if (!domainCtrl.pwr1On)
    begin
      // Contents gone with the supply
      retCount <= lostData;
    end
    else if (domainCtrl.restoreEdge)
    begin
      retCount <= savedCount;
    end
    else if (work && clkEn)
    begin
      retCount <= retCount + domainData_t'(1);
    end
  end

  // ------------------------------
  // Non-retained register
  // ------------------------------
  always_ff @(posedge pclk12 or negedge nprst12)
  begin
    if (!nprst12)
    begin
      plainReg <= '0;
    end
    else if (!railsUp)
    begin
      plainReg <= lostData;
    end
    else if (!domainCtrl.rstnNonSrpg)
    begin
      // Powered but held in the PSO reset
      plainReg <= '0;
    end
    else if (work && clkEn)
    begin
      plainReg <= dataIn;
    end
  end

  assign liveCount = retCount;

  // Output clamp while isolated
  assign dataOut = domainCtrl.isolate ? '0 : (retCount + plainReg);

endmodule

`default_nettype wire

//--- psoSequencer.sv
/*
  Power shut-off sequencer for one domain.
  The request is looked at only in Init and PwrOff, so a request dropped
  mid-sequence still runs to PwrOff before waking.
  All domain controls are flops loaded from the next state.
  rstnNonSrpg is also forced low by the chip reset.
*/
`timescale 1ns/1ps
`default_nettype none

module psoSequencer
  import pwrCtrlPkg::*;
(
  input  logic        pclk12,
  input  logic        nprst12,
  input  logic        lowPwrReq,
  output logic        setStatus,
  output logic        clrStatus,
  output domainCtrl_t domainCtrl
);

  psoState_t    curState;
  psoState_t    nextState;
  stableCount_t stableCnt;
  logic         stableDone;
  domainCtrl_t  ctrlQ;

  // Control levels wanted while sitting in a given state
  function automatic domainCtrl_t ctrlFor(psoState_t s);
    domainCtrl_t c;
    // Clocks stay gated until the wake-up tail
    c.gateClk     = !(s inside {ClkOn, Wait3, RstClr, Init});
    // Outputs clamped across save, off and restore
    c.isolate     = s inside {Isolate, SaveEdge, PrePwrOff, PwrOff,
                              PwrOn1, PwrOn2, RestoreEdge, Wait2};
    // Non-retained flops held in reset from power-off until clocks run
    c.rstnNonSrpg = !(s inside {PwrOff, PwrOn1, PwrOn2, RestoreEdge,
                                Wait2, DeIsolate, ClkOn, Wait3});
    c.saveEdge    = (s == SaveEdge);
    c.restoreEdge = (s == RestoreEdge);
    // Staged power-on: switch 1 first, switch 2 a cycle later
    c.pwr1On      = (s != PwrOff);
    c.pwr2On      = !(s inside {PwrOff, PwrOn1});
    return c;
  endfunction

  // ------------------------------
  // Next-state logic
  // ------------------------------
  always_comb
  begin
    nextState = curState;
    case (curState)
      Init:
      begin
        // Start shut-off once software asks for it
        if (lowPwrReq)
        begin
          nextState = ClkOff;
        end
      end
      ClkOff:      nextState = Wait1;
      // Let the clock gate settle before isolating
      Wait1:       nextState = Isolate;
      Isolate:     nextState = SaveEdge;
      SaveEdge:    nextState = PrePwrOff;
      PrePwrOff:   nextState = PwrOff;
      PwrOff:
      begin
        // Stay off until the request is dropped
        if (!lowPwrReq)
        begin
          nextState = PwrOn1;
        end
      end
      PwrOn1:      nextState = PwrOn2;
      PwrOn2:
      begin
        if (stableDone)
        begin
          nextState = RestoreEdge;
        end
      end
      RestoreEdge: nextState = Wait2;
      Wait2:       nextState = DeIsolate;
      DeIsolate:   nextState = ClkOn;
      // Wait for the clock to run again before releasing reset
      ClkOn:       nextState = Wait3;
      Wait3:       nextState = RstClr;
      RstClr:      nextState = Init;
      default:     nextState = Init;
    endcase
  end

  // ------------------------------
  // State register
  // ------------------------------
  always_ff @(posedge pclk12 or negedge nprst12)
  begin
    if (!nprst12)
    begin
      curState <= Init;
    end
    else
    begin
      curState <= nextState;
    end
  end

  // ------------------------------
  // Settling counter
  // ------------------------------
  // Zero outside PwrOn2, so every entry starts a fresh count
  always_ff @(posedge pclk12 or negedge nprst12)
  begin
    if (!nprst12)
    begin
      stableCnt <= '0;
    end
    else if (curState != PwrOn2)
    begin
      stableCnt <= '0;
    end
    else
    begin
      stableCnt <= stableCnt + stableCount_t'(1);
    end
  end

  // Last of the settling cycles
  assign stableDone = (stableCnt == stableCount_t'(pwrStableCycles - 1));

  // ------------------------------
  // Registered domain controls
  // ------------------------------
  always_ff @(posedge pclk12 or negedge nprst12)
  begin
    if (!nprst12)
    begin
      // Powered, ungated, not isolated; non-retained flops in reset
      ctrlQ <= '{gateClk: 1'b0, isolate: 1'b0, rstnNonSrpg: 1'b0,
                 saveEdge: 1'b0, restoreEdge: 1'b0,
                 pwr1On: 1'b1, pwr2On: 1'b1};
    end
    else
    begin
      ctrlQ <= ctrlFor(nextState);
    end
  end

  // Chip reset also resets the non-retained flops
  always_comb
  begin
    domainCtrl             = ctrlQ;
    domainCtrl.rstnNonSrpg = ctrlQ.rstnNonSrpg & nprst12;
  end

  // Status pulses for the request block
  assign setStatus = (nextState == ClkOff);
  assign clrStatus = (curState == RstClr);

endmodule

`default_nettype wire

//--- pwrCtrlPkg.sv
/*
  Shared types and constants for the single-domain PSO controller.
  One switchable domain only; power switches are modelled as plain levels.
  Domain data is 16 bits wide; the settling count fits in 5 bits.
*/
`default_nettype none

package pwrCtrlPkg;

  // ------------------------------
  // Sequencer states
  // ------------------------------
  typedef enum logic [3:0] {
    Init        = 4'd0,
    ClkOff      = 4'd1,
    Wait1       = 4'd2,
    Isolate     = 4'd3,
    SaveEdge    = 4'd4,
    PrePwrOff   = 4'd5,
    PwrOff      = 4'd6,
    PwrOn1      = 4'd7,
    PwrOn2      = 4'd8,
    RestoreEdge = 4'd9,
    Wait2       = 4'd10,
    DeIsolate   = 4'd11,
    ClkOn       = 4'd12,
    Wait3       = 4'd13,
    RstClr      = 4'd14
  } psoState_t;

  // Domain register contents
  typedef logic [15:0] domainData_t;

  // Settling counter for the staged power-on
  typedef logic [4:0] stableCount_t;

  // Cycles spent in PwrOn2 before restore
  localparam int unsigned pwrStableCycles = 28;

  // Value left in a register whose supply is off
  localparam domainData_t lostData = 16'hdead;

  // Controls from the sequencer to the switchable domain
  typedef struct packed {
    logic gateClk;
    logic isolate;
    logic rstnNonSrpg;
    logic saveEdge;
    logic restoreEdge;
    logic pwr1On;
    logic pwr2On;
  } domainCtrl_t;

endpackage

`default_nettype wire

//--- pwrCtrlProperties.sv
/*
  Concurrent checks on the PSO sequencer outputs, bound into psoSequencer.
  Disabled while nprst12 is low.
  failCount is read by the testbench at the end of the run.
*/
`timescale 1ns/1ps
`default_nettype none

module pwrCtrlProperties
  import pwrCtrlPkg::*;
(
  input  logic        pclk12,
  input  logic        nprst12,
  input  psoState_t   curState,
  input  logic        setStatus,
  input  logic        clrStatus,
  input  domainCtrl_t domainCtrl
);

  int unsigned failCount = 0;

  // ------------------------------
  // Status pulses
  // ------------------------------
  statusPulsesExclusive: assert property (
    @(posedge pclk12) disable iff (!nprst12)
    !(setStatus && clrStatus)
  )
  else
  begin
    failCount++;
    $error("setStatus and clrStatus high together in %s", curState.name());
  end

  // ------------------------------
  // Shutdown ordering
  // ------------------------------
  // Gate rose two samples back and was still low three samples back
  isolateTwoAfterGate: assert property (
    @(posedge pclk12) disable iff (!nprst12)
    $rose(domainCtrl.isolate) |-> $past(domainCtrl.gateClk, 2) && !$past(domainCtrl.gateClk, 3)
  )
  else
  begin
    failCount++;
    $error("isolate did not rise two cycles after gateClk, state %s", curState.name());
  end

  // Both switches open on the same edge
  switchesFallTogether: assert property (
    @(posedge pclk12) disable iff (!nprst12)
    $fell(domainCtrl.pwr1On) |-> $fell(domainCtrl.pwr2On)
  )
  else
  begin
    failCount++;
    $error("pwr1On fell without pwr2On, state %s", curState.name());
  end

endmodule

`default_nettype wire

//--- pwrCtrlTb.sv
/*
  Directed testbench for the PSO controller top level.
  Inputs change 1 ns after the rising edge and outputs are checked there too.
  Keeps its own model of the domain counter and the last captured data.
*/
`timescale 1ns/1ps
`default_nettype none

module pwrCtrlTb
  import pwrCtrlPkg::*;
;

  localparam int unsigned resetCycles   = 8;
  localparam logic [31:0] lfsrSeed      = 32'hbd44;
  // Tests need roughly 180 cycles, so this leaves a wide margin
  localparam int unsigned timeoutCycles = 600;

  logic        pclk12  = 1'b0;
  logic        nprst12 = 1'b0;
  logic        reqSet  = 1'b0;
  logic        reqClr  = 1'b0;
  logic        work    = 1'b0;
  domainData_t dataIn  = '0;
  logic        lowPwrStatus;
  domainCtrl_t domainCtrl;
  domainData_t dataOut;

  int unsigned checkTotal = 0;
  int unsigned errCount   = 0;
  int unsigned cycleCount = 0;
  logic [31:0] lfsrState  = lfsrSeed;
  // Expected retained count and last captured data
  domainData_t modelCount = '0;
  domainData_t modelData  = '0;

  pwrCtrlTop pwrCtrlTop_i (
    .pclk12       (pclk12),
    .nprst12      (nprst12),
    .reqSet       (reqSet),
    .reqClr       (reqClr),
    .work         (work),
    .dataIn       (dataIn),
    .lowPwrStatus (lowPwrStatus),
    .domainCtrl   (domainCtrl),
    .dataOut      (dataOut)
  );

  bind psoSequencer pwrCtrlProperties pwrCtrlProperties_i (
    .pclk12     (pclk12),
    .nprst12    (nprst12),
    .curState   (curState),
    .setStatus  (setStatus),
    .clrStatus  (clrStatus),
    .domainCtrl (domainCtrl)
  );

  // 4 ns period
  always #2 pclk12 = !pclk12;

  // Watchdog
  always @(posedge pclk12)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles)
    begin
      $display("Timeout: the tests did not finish within %0d clock cycles", timeoutCycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic drawBits(input int unsigned n, output domainData_t v);
    int unsigned i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      lfsrState = lfsrStep(lfsrState);
      v = {v[14:0], lfsrState[0]};
    end
  endtask

  // Rising edge, then 1 ns for outputs to settle
  task automatic stepCycle();
    @(posedge pclk12);
    #1;
  endtask

  function automatic domainCtrl_t makeCtrl(input logic gate, input logic iso, input logic rstn,
                                           input logic save, input logic restore,
                                           input logic p1, input logic p2);
    domainCtrl_t c;
    c.gateClk     = gate;
    c.isolate     = iso;
    c.rstnNonSrpg = rstn;
    c.saveEdge    = save;
    c.restoreEdge = restore;
    c.pwr1On      = p1;
    c.pwr2On      = p2;
    return c;
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic checkBit(input logic got, input logic exp, input string what);
    checkTotal++;
    if (got !== exp)
    begin
      errCount++;
      $display("FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkData(input domainData_t got, input domainData_t exp, input string what);
    checkTotal++;
    if (got !== exp)
    begin
      errCount++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkCtrl(input domainCtrl_t got, input domainCtrl_t exp, input string what);
    checkTotal++;
    if (got !== exp)
    begin
      errCount++;
      $display("FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkCount(input stableCount_t got, input stableCount_t exp,
                            input string what);
    checkTotal++;
    if (got !== exp)
    begin
      errCount++;
      $display("FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic resetValues();
    repeat (resetCycles) stepCycle();
    nprst12 = 1'b1;
    #1;
    // Powered, ungated, non-retained flops still in reset
    checkCtrl(domainCtrl, makeCtrl(0, 0, 0, 0, 0, 1, 1), "controls after reset");
    checkBit(lowPwrStatus, 1'b0, "status after reset");
    checkData(dataOut, '0, "dataOut after reset");
    stepCycle();
    checkCtrl(domainCtrl, makeCtrl(0, 0, 1, 0, 0, 1, 1), "controls one edge after reset");
  endtask

  // Random work and data while the domain runs
  task automatic normalOperation(input int unsigned cycles);
    domainData_t bits;
    domainData_t newData;
    int unsigned i;
    for (i = 0; i < cycles; i++)
    begin
      drawBits(1, bits);
      drawBits(16, newData);
      work   = bits[0];
      dataIn = newData;
      stepCycle();
      if (bits[0])
      begin
        modelCount = modelCount + domainData_t'(1);
        modelData  = newData;
      end
      checkData(dataOut, modelCount + modelData, "dataOut in normal operation");
    end
    work = 1'b0;
  endtask

  // Offsets counted from the edge after which reqSet is driven
  task automatic shutdownTiming();
    int unsigned k;
    reqSet = 1'b1;
    for (k = 1; k <= 7; k++)
    begin
      stepCycle();
      reqSet = 1'b0;
      // Work while gated but still powered must not reach the saved count
      work   = (k >= 2);
      checkCtrl(domainCtrl, makeCtrl(k >= 2, k >= 4, k < 7, k == 5, 0, k < 7, k < 7),
                $sformatf("controls %0d cycles after reqSet", k));
      checkBit(lowPwrStatus, k >= 2, "status during shutdown");
    end
  endtask

  // Domain sits in power-off and work must be lost
  task automatic gatingIsolation(input int unsigned cycles);
    domainData_t newData;
    int unsigned i;
    for (i = 0; i < cycles; i++)
    begin
      drawBits(16, newData);
      work   = 1'b1;
      dataIn = newData;
      stepCycle();
      checkData(dataOut, '0, "dataOut while powered off");
      checkCtrl(domainCtrl, makeCtrl(1, 1, 0, 0, 0, 0, 0), "controls while powered off");
    end
    work = 1'b0;
  endtask

  task automatic wakeRetention();
    int unsigned n;
    int unsigned j;
    reqClr = 1'b1;
    stepCycle();
    reqClr = 1'b0;
    while (!domainCtrl.pwr1On)
    begin
      stepCycle();
    end
    checkBit(domainCtrl.pwr2On, 1'b0, "second switch open as the first closes");
    stepCycle();
    checkBit(domainCtrl.pwr2On, 1'b1, "second switch one cycle after the first");
    n = 0;
    while (!domainCtrl.restoreEdge)
    begin
      stepCycle();
      n++;
    end
    checkCount(stableCount_t'(n), stableCount_t'(pwrStableCycles), "settling cycles");
    // Non-retained register stays cleared after restore
    modelData = '0;
    for (j = 1; j <= 6; j++)
    begin
      stepCycle();
      checkCtrl(domainCtrl, makeCtrl(j < 3, j < 2, j >= 5, 0, 0, 1, 1),
                $sformatf("controls %0d cycles after restore", j));
      checkBit(lowPwrStatus, j < 6, "status during wake-up");
      checkData(dataOut, (j < 2) ? domainData_t'(0) : modelCount, "dataOut after restore");
    end
  endtask

  // Request dropped while shutdown is still running
  task automatic earlyDrop();
    reqSet = 1'b1;
    stepCycle();
    reqSet = 1'b0;
    stepCycle();
    reqClr = 1'b1;
    stepCycle();
    reqClr = 1'b0;
    while (domainCtrl.pwr1On)
    begin
      stepCycle();
    end
    checkBit(lowPwrStatus, 1'b1, "status at power-off after early drop");
    stepCycle();
    checkBit(domainCtrl.pwr1On, 1'b1, "power back after one off cycle");
    modelData = '0;
    while (lowPwrStatus)
    begin
      stepCycle();
    end
    checkCtrl(domainCtrl, makeCtrl(0, 0, 1, 0, 0, 1, 1), "controls after early-drop wake");
    checkData(dataOut, modelCount, "count restored after early drop");
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial
  begin
    int unsigned assertFails;
    resetValues();
    normalOperation(24);
    shutdownTiming();
    gatingIsolation(6);
    wakeRetention();
    normalOperation(24);
    earlyDrop();
    normalOperation(16);
    assertFails = pwrCtrlTop_i.psoSequencer_i.pwrCtrlProperties_i.failCount;
    $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
             checkTotal, errCount, assertFails);
    if (errCount == 0 && assertFails == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- pwrCtrlTop.sv
/*
  PSO controller top: request registers, sequencer, retention store
  and the switchable domain model.
  Software drives reqSet and reqClr as single-cycle pulses.
*/
`timescale 1ns/1ps
`default_nettype none

module pwrCtrlTop
  import pwrCtrlPkg::*;
(
  input  logic        pclk12,
  input  logic        nprst12,
  input  logic        reqSet,
  input  logic        reqClr,
  input  logic        work,
  input  domainData_t dataIn,
  output logic        lowPwrStatus,
  output domainCtrl_t domainCtrl,
  output domainData_t dataOut
);

  logic        lowPwrReq;
  logic        setStatus;
  logic        clrStatus;
  domainData_t liveCount;
  domainData_t savedCount;

  // ------------------------------
  // Control path
  // ------------------------------
  pwrReqRegs pwrReqRegs_i (
    .pclk12       (pclk12),
    .nprst12      (nprst12),
    .reqSet       (reqSet),
    .reqClr       (reqClr),
    .setStatus    (setStatus),
    .clrStatus    (clrStatus),
    .lowPwrReq    (lowPwrReq),
    .lowPwrStatus (lowPwrStatus)
  );

  psoSequencer psoSequencer_i (
    .pclk12     (pclk12),
    .nprst12    (nprst12),
    .lowPwrReq  (lowPwrReq),
    .setStatus  (setStatus),
    .clrStatus  (clrStatus),
    .domainCtrl (domainCtrl)
  );

  // ------------------------------
  // Domain and its shadow
  // ------------------------------
  retentionStore retentionStore_i (
    .pclk12     (pclk12),
    .nprst12    (nprst12),
    .domainCtrl (domainCtrl),
    .liveCount  (liveCount),
    .savedCount (savedCount)
  );

  gatedDomain gatedDomain_i (
    .pclk12     (pclk12),
    .nprst12    (nprst12),
    .work       (work),
    .dataIn     (dataIn),
    .domainCtrl (domainCtrl),
    .savedCount (savedCount),
    .liveCount  (liveCount),
    .dataOut    (dataOut)
  );

endmodule

`default_nettype wire

//--- pwrReqRegs.sv
/*
  Software request bit and low-power status bit.
  reqSet and reqClr are one-cycle strobes; set wins if both arrive together.
  Status follows the sequencer pulses only, never the strobes.
*/
`timescale 1ns/1ps
`default_nettype none

module pwrReqRegs
  import pwrCtrlPkg::*;
(
  input  logic pclk12,
  input  logic nprst12,
  // Software strobes
  input  logic reqSet,
  input  logic reqClr,
  // Pulses from the sequencer
  input  logic setStatus,
  input  logic clrStatus,
  // Level towards the sequencer
  output logic lowPwrReq,
  // Domain is in low power
  output logic lowPwrStatus
);

  // ------------------------------
  // Request bit
  // ------------------------------
  always_ff @(posedge pclk12 or negedge nprst12)
  begin
    if (!nprst12)
    begin
      lowPwrReq <= 1'b0;
    end
    else if (reqSet)
    begin
      // Set has priority over clear
      lowPwrReq <= 1'b1;
    end
    else if (reqClr)
    begin
      lowPwrReq <= 1'b0;
    end
  end

  // ------------------------------
  // Status bit
  // ------------------------------
  always_ff @(posedge pclk12 or negedge nprst12)
  begin
    if (!nprst12)
    begin
      lowPwrStatus <= 1'b0;
    end
    else if (setStatus)
    begin
      // Raised as the clocks are about to be gated
      lowPwrStatus <= 1'b1;
    end
    else if (clrStatus)
    begin
      // Dropped as the non-retention reset is released
      lowPwrStatus <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- retentionStore.sv
/*
  Always-on shadow register for the domain's retained counter.
  Loads on saveEdge only and holds through power-off.
  Its supply is assumed never to switch off with the domain.
*/
`timescale 1ns/1ps
`default_nettype none

module retentionStore
  import pwrCtrlPkg::*;
(
  input  logic        pclk12,
  input  logic        nprst12,
  input  domainCtrl_t domainCtrl,
  // Live value of the retained register
  input  domainData_t liveCount,
  // Shadow copy offered back on restore
  output domainData_t savedCount
);

  domainData_t shadowQ;

  // ------------------------------
  // Balloon latch
  // ------------------------------
  always_ff @(posedge pclk12 or negedge nprst12)
  begin
    if (!nprst12)
    begin
      shadowQ <= '0;
    end
    else if (domainCtrl.saveEdge)
    begin
      // Capture while the domain is still powered and isolated
      shadowQ <= liveCount;
    end
  end

  // Presented all the time; the domain takes it on restoreEdge
  assign savedCount = shadowQ;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the PSO controller testbench with Verilator.
# The result is taken from the testbench's own closing message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module pwrCtrlTb \
  -f vlog.f

# Assertion errors are counted by the testbench, so the run must not stop on the first
simOutput=$(./obj_dir/VpwrCtrlTb +verilator+error+limit+1000 2>&1 || true)
echo "$simOutput"

if grep -qx "Simulation PASSED" <<< "$simOutput"
then
  exit 0
fi
exit 1

//--- vlog.f
pwrCtrlPkg.sv
pwrReqRegs.sv
psoSequencer.sv
retentionStore.sv
gatedDomain.sv
pwrCtrlTop.sv
pwrCtrlProperties.sv
pwrCtrlTb.sv
